// File: common/disk_consts.svh
`ifndef DISK_CONSTS_SVH
`define DISK_CONSTS_SVH

`define DISK_WORDS 500
`define IMEM_WORDS 256
`define FIFO_DEPTH 4

// register map, byte offsets
`define REG_CTRL      5'h00
`define REG_SRC       5'h04
`define REG_DST       5'h08
`define REG_LEN       5'h0C
`define REG_DISK_ADDR 5'h10
`define REG_DISK_DATA 5'h14
`define REG_IMEM_ADDR 5'h18
`define REG_IMEM_DATA 5'h1C

`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif

// File: common/disk_pkg.sv
`default_nettype none

package disk_pkg;

	typedef logic [31:0] disk_word_t;	// one disk or instruction word
	typedef logic [8:0]  disk_addr_t;	// 500 of 512 words exist
	typedef logic [7:0]  imem_addr_t;	// wraps at 256
	typedef logic [8:0]  xfer_len_t;	// 0 is an empty transfer
	typedef logic [4:0]  reg_addr_t;	// register byte address

	// block reader sequencing
	typedef enum logic [1:0] {
		IDLE,
		STREAM,
		DRAIN
	} loader_state_t;

endpackage

`default_nettype wire

// File: dv/disk_loader_sva.sv
`default_nettype none
`include "disk_consts.svh"

module disk_loader_sva
	import disk_pkg::*;
(
	input logic                          clk,
	input logic                          rst_n,
	input logic                          bvalid,
	input logic                          bready,
	input logic [1:0]                    bresp,
	input logic                          rvalid,
	input logic                          rready,
	input disk_word_t                    rdata,
	input logic [1:0]                    rresp,
	input logic                          push,
	input logic                          pop,
	input logic                          empty,
	input logic [$clog2(`FIFO_DEPTH):0]  fill,
	input logic                          busy,
	input logic                          xfer_done
);

	timeunit 1ns;
	timeprecision 1ps;

	a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("write response dropped or changed before bready");

	a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("read data dropped or changed before rready");

	// push into a full FIFO without a pop
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push && !pop |-> fill < `FIFO_DEPTH)
		else $error("FIFO overflow");

	// every pushed word is drained before the transfer ends
	a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> empty && !push && !pop)
		else $error("FIFO traffic or leftover words while not busy");

	a_done_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
		xfer_done |-> busy)
		else $error("transfer completion outside a busy transfer");

endmodule

bind disk_loader_top disk_loader_sva i_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.bvalid    (bvalid),
	.bready    (bready),
	.bresp     (bresp),
	.rvalid    (rvalid),
	.rready    (rready),
	.rdata     (rdata),
	.rresp     (rresp),
	.push      (push),
	.pop       (pop),
	.empty     (empty),
	.fill      (fill),
	.busy      (i_regs.busy),
	.xfer_done (xfer_done)
);

`default_nettype wire

// File: dv/disk_loader_tb.sv
`default_nettype none
`include "disk_consts.svh"

module disk_loader_tb
	import disk_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_DISK_RW = 60;
	localparam int N_RAND_XFER = 3;
	localparam int N_XFERS = N_RAND_XFER + 5;	// init, back-pressure, busy, empty, overrun
	localparam int BP_LEN = 100;
	localparam int BUSY_LEN = 200;	// long enough to stay busy through the probes
	localparam int OVR_LEN = 20;
	localparam int ACCESSES = 2 * `DISK_WORDS + 4 * N_DISK_RW + 28
		+ N_XFERS * (20 + 2 * `IMEM_WORDS);
	localparam int WORDS = `IMEM_WORDS + 40 * N_RAND_XFER + BP_LEN + BUSY_LEN + OVR_LEN;
	localparam int CYCLE_LIMIT = 2 * (40 * ACCESSES + 10 * WORDS);

	logic       clk;
	logic       rst_n;
	reg_addr_t  awaddr;
	logic       awvalid;
	logic       awready;
	disk_word_t wdata;
	logic       wvalid;
	logic       wready;
	logic [1:0] bresp;
	logic       bvalid;
	logic       bready;
	reg_addr_t  araddr;
	logic       arvalid;
	logic       arready;
	disk_word_t rdata;
	logic [1:0] rresp;
	logic       rvalid;
	logic       rready;

	disk_word_t  disk_model [512];	// words 500 and up stay zero
	disk_word_t  imem_model [`IMEM_WORDS];
	logic [31:0] lfsr = 32'd96395;
	int          error_count = 0;
	int          cycles = 0;

	disk_loader_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the DUT stopped responding", cycles);
		stop_on_error();
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		logic        fb;
		int          i;
		value = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	task automatic stop_on_error();
		error_count++;
		$display("FAIL: see errors above");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_word(input string name, input disk_word_t exp, input disk_word_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_status(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			$display("FAILED %s: expected done/busy %b, actual %b", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			$display("FAILED %s: expected resp %b, actual %b", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic axi_write(input reg_addr_t addr, input disk_word_t data,
			output logic [1:0] resp);
		logic aw_ok;
		logic w_ok;
		logic aw_done;
		logic w_done;
		aw_done = 1'b0;
		w_done = 1'b0;
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wvalid <= 1'b1;
		while (!(aw_done && w_done)) begin
			@(negedge clk);
			aw_ok = awvalid && awready;	// handshake happens at the next edge
			w_ok = wvalid && wready;
			@(posedge clk);
			if (aw_ok) begin
				awvalid <= 1'b0;
				aw_done = 1'b1;
			end
			if (w_ok) begin
				wvalid <= 1'b0;
				w_done = 1'b1;
			end
		end
		repeat (rand_bits(2)) @(posedge clk);
		bready <= 1'b1;
		do begin
			@(negedge clk);
		end while (!bvalid);
		resp = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input reg_addr_t addr, output disk_word_t data,
			output logic [1:0] resp);
		logic ar_ok;
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		do begin
			@(negedge clk);
			ar_ok = arready;
			@(posedge clk);
		end while (!ar_ok);
		arvalid <= 1'b0;
		repeat (rand_bits(2)) @(posedge clk);
		rready <= 1'b1;
		do begin
			@(negedge clk);
		end while (!rvalid);
		data = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic reg_write(input string name, input reg_addr_t addr, input disk_word_t data,
			input logic [1:0] exp_resp);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check_resp(name, exp_resp, resp);
	endtask

	task automatic reg_read(input string name, input reg_addr_t addr, input logic [1:0] exp_resp,
			output disk_word_t data);
		logic [1:0] resp;
		axi_read(addr, data, resp);
		check_resp(name, exp_resp, resp);
	endtask

	task automatic disk_write(input disk_addr_t addr, input disk_word_t data);
		reg_write("disk_addr", `REG_DISK_ADDR, disk_word_t'(addr), `RESP_OKAY);
		reg_write("disk_data", `REG_DISK_DATA, data, `RESP_OKAY);
		if (addr < `DISK_WORDS) begin
			disk_model[addr] = data;
		end
	endtask

	task automatic disk_check(input string name, input disk_addr_t addr);
		disk_word_t data;
		reg_write(name, `REG_DISK_ADDR, disk_word_t'(addr), `RESP_OKAY);
		reg_read(name, `REG_DISK_DATA, `RESP_OKAY, data);
		check_word(name, disk_model[addr], data);
	endtask

	// word i of the block lands at (dst + i) mod 256, zero past the disk end
	function automatic void model_copy(input disk_addr_t s, input imem_addr_t d,
			input xfer_len_t n);
		int         i;
		int         idx;
		imem_addr_t dst_i;
		for (i = 0; i < int'(n); i++) begin
			idx = int'(s) + i;
			dst_i = d + imem_addr_t'(i);
			imem_model[dst_i] = (idx < `DISK_WORDS) ? disk_model[idx] : '0;
		end
	endfunction

	task automatic verify_imem(input string name);
		disk_word_t data;
		int         i;
		for (i = 0; i < `IMEM_WORDS; i++) begin
			reg_write(name, `REG_IMEM_ADDR, disk_word_t'(i), `RESP_OKAY);
			reg_read(name, `REG_IMEM_DATA, `RESP_OKAY, data);
			check_word(name, imem_model[i], data);
		end
	endtask

	task automatic start_transfer(input disk_addr_t s, input imem_addr_t d, input xfer_len_t n);
		reg_write("set_src", `REG_SRC, disk_word_t'(s), `RESP_OKAY);
		reg_write("set_dst", `REG_DST, disk_word_t'(d), `RESP_OKAY);
		reg_write("set_len", `REG_LEN, disk_word_t'(n), `RESP_OKAY);
		reg_write("start", `REG_CTRL, 32'h1, `RESP_OKAY);
	endtask

	task automatic finish_transfer(input string name, input disk_addr_t s, input imem_addr_t d,
			input xfer_len_t n);
		disk_word_t status;
		do begin
			reg_read(name, `REG_CTRL, `RESP_OKAY, status);
		end while (!status[1]);
		reg_read(name, `REG_CTRL, `RESP_OKAY, status);
		check_status(name, 2'b10, status[1:0]);
		model_copy(s, d, n);
		verify_imem(name);
	endtask

	initial begin
		disk_addr_t addrs [N_DISK_RW];
		disk_addr_t s;
		disk_addr_t a;
		imem_addr_t d;
		xfer_len_t  n;
		disk_word_t data;
		int         i;
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		for (i = 0; i < 512; i++) begin
			disk_model[i] = '0;
		end
		for (i = 0; i < `IMEM_WORDS; i++) begin
			imem_model[i] = '0;
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// every disk and imem word gets a known value first
		for (i = 0; i < `DISK_WORDS; i++) begin
			disk_write(disk_addr_t'(i), rand_bits(32));
		end
		start_transfer('0, '0, xfer_len_t'(`IMEM_WORDS));
		finish_transfer("imem_init", '0, '0, xfer_len_t'(`IMEM_WORDS));

		for (i = 0; i < N_DISK_RW; i++) begin
			addrs[i] = disk_addr_t'(rand_bits(9));
			disk_write(addrs[i], rand_bits(32));
		end
		for (i = 0; i < N_DISK_RW; i++) begin
			disk_check("disk_rw", addrs[i]);
		end
		disk_check("disk_out_of_range", 9'd500);
		disk_check("disk_out_of_range", 9'd511);

		for (i = 0; i < N_RAND_XFER; i++) begin
			s = disk_addr_t'(rand_bits(9));
			d = imem_addr_t'(rand_bits(8));
			n = xfer_len_t'(rand_bits(6) % 40 + 1);
			start_transfer(s, d, n);
			finish_transfer("block_xfer", s, d, n);
		end

		// host reads steal the imem port from the drain
		s = disk_addr_t'(rand_bits(8));
		d = imem_addr_t'(rand_bits(8));
		reg_write("bp_addr", `REG_IMEM_ADDR, disk_word_t'(d + 8'd4), `RESP_OKAY);
		start_transfer(s, d, xfer_len_t'(BP_LEN));
		repeat (12) reg_read("bp_read", `REG_IMEM_DATA, `RESP_OKAY, data);
		finish_transfer("backpressure", s, d, xfer_len_t'(BP_LEN));

		s = disk_addr_t'(rand_bits(8));
		d = imem_addr_t'(rand_bits(8));
		a = disk_addr_t'(rand_bits(8));
		reg_write("busy_setup", `REG_DISK_ADDR, disk_word_t'(a), `RESP_OKAY);
		start_transfer(s, d, xfer_len_t'(BUSY_LEN));
		reg_read("busy_status", `REG_CTRL, `RESP_OKAY, data);
		check_status("busy_status", 2'b01, data[1:0]);
		reg_write("busy_disk_write", `REG_DISK_DATA, ~disk_model[a], `RESP_SLVERR);
		reg_read("busy_disk_read", `REG_DISK_DATA, `RESP_SLVERR, data);
		check_word("busy_disk_read", '0, data);
		reg_write("busy_restart", `REG_DST, disk_word_t'(d ^ 8'h80), `RESP_OKAY);
		reg_write("busy_restart", `REG_CTRL, 32'h1, `RESP_OKAY);	// must not restart
		finish_transfer("busy", s, d, xfer_len_t'(BUSY_LEN));
		disk_check("busy_disk_kept", a);

		reg_write("unmapped_write", 5'h02, rand_bits(32), `RESP_SLVERR);
		reg_write("imem_data_write", `REG_IMEM_DATA, rand_bits(32), `RESP_SLVERR);
		reg_read("unmapped_read", 5'h1E, `RESP_SLVERR, data);

		s = disk_addr_t'(rand_bits(9));
		d = imem_addr_t'(rand_bits(8));
		start_transfer(s, d, '0);
		finish_transfer("empty_xfer", s, d, '0);

		// block runs past word 499
		d = imem_addr_t'(rand_bits(8));
		start_transfer(9'd490, d, xfer_len_t'(OVR_LEN));
		finish_transfer("overrun", 9'd490, d, xfer_len_t'(OVR_LEN));

		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/disk_loader_regs.sv
`default_nettype none
`include "disk_consts.svh"

module disk_loader_regs
	import disk_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  reg_addr_t  awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  disk_word_t wdata,
	input  logic       wvalid,
	output logic       wready,
	output logic [1:0] bresp,
	output logic       bvalid,
	input  logic       bready,
	input  reg_addr_t  araddr,
	input  logic       arvalid,
	output logic       arready,
	output disk_word_t rdata,
	output logic [1:0] rresp,
	output logic       rvalid,
	input  logic       rready,
	output logic       start,
	output disk_addr_t src,
	output imem_addr_t dst,
	output xfer_len_t  len,
	output logic       host_en,
	output logic       host_we,
	output disk_addr_t host_addr,
	output disk_word_t host_wdata,
	input  disk_word_t host_rdata,
	output logic       imem_rd,
	output imem_addr_t imem_addr,
	input  disk_word_t imem_rdata,
	input  logic       xfer_done
);

	reg_addr_t  aw_addr_q;
	logic       aw_held;	// address arrived ahead of data
	disk_word_t w_data_q;
	logic       w_held;
	logic       aw_hs;
	logic       w_hs;
	logic       wr_fire;
	reg_addr_t  wr_addr;
	disk_word_t wr_data;
	logic [1:0] wr_resp;
	logic       ar_hs;
	logic       rd_pend;	// memory read under way
	logic       rd_imem;
	logic       rd_err;
	disk_word_t rd_value;
	logic [1:0] rd_resp;
	logic       busy;
	logic       done;

	assign awready = !bvalid && !aw_held;
	assign wready = !bvalid && !w_held;
	assign aw_hs = awvalid && awready;
	assign w_hs = wvalid && wready;
	assign wr_fire = (aw_held || aw_hs) && (w_held || w_hs);
	assign wr_addr = aw_held ? aw_addr_q : awaddr;
	assign wr_data = w_held ? w_data_q : wdata;

	// a write completing this cycle may need the disk port
	assign arready = !rvalid && !rd_pend && !wr_fire;
	assign ar_hs = arvalid && arready;

	assign host_we = wr_fire && (wr_addr == `REG_DISK_DATA) && !busy;
	assign host_en = host_we || (ar_hs && (araddr == `REG_DISK_DATA) && !busy);
	assign host_wdata = wr_data;
	assign imem_rd = ar_hs && (araddr == `REG_IMEM_DATA);

	always_comb begin
		case (wr_addr)
			`REG_CTRL, `REG_SRC, `REG_DST, `REG_LEN,
			`REG_DISK_ADDR, `REG_IMEM_ADDR: wr_resp = `RESP_OKAY;
			`REG_DISK_DATA: wr_resp = busy ? `RESP_SLVERR : `RESP_OKAY;
			default: wr_resp = `RESP_SLVERR;	// IMEM_DATA is read only
		endcase
	end

	always_comb begin
		rd_resp = `RESP_OKAY;
		case (araddr)
			`REG_CTRL: rd_value = {30'b0, done, busy};
			`REG_SRC: rd_value = disk_word_t'(src);
			`REG_DST: rd_value = disk_word_t'(dst);
			`REG_LEN: rd_value = disk_word_t'(len);
			`REG_DISK_ADDR: rd_value = disk_word_t'(host_addr);
			`REG_IMEM_ADDR: rd_value = disk_word_t'(imem_addr);
			default: begin
				rd_value = '0;
				rd_resp = `RESP_SLVERR;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (aw_hs) begin
			aw_addr_q <= awaddr;
		end
		if (w_hs) begin
			w_data_q <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			bvalid <= 1'b0;
			bresp <= `RESP_OKAY;
			start <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			src <= '0;
			dst <= '0;
			len <= '0;
			host_addr <= '0;
			imem_addr <= '0;
		end else begin
			start <= 1'b0;
			if (xfer_done) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (wr_fire) begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
				bvalid <= 1'b1;
				bresp <= wr_resp;
				case (wr_addr)
					`REG_CTRL: begin
						if (wr_data[0] && !busy) begin	// start while busy is ignored
							start <= 1'b1;
							busy <= 1'b1;
							done <= 1'b0;
						end
					end
					`REG_SRC: src <= wr_data[8:0];
					`REG_DST: dst <= wr_data[7:0];
					`REG_LEN: len <= wr_data[8:0];
					`REG_DISK_ADDR: host_addr <= wr_data[8:0];
					`REG_IMEM_ADDR: imem_addr <= wr_data[7:0];
					default: ;
				endcase
			end else begin
				if (aw_hs) begin
					aw_held <= 1'b1;
				end
				if (w_hs) begin
					w_held <= 1'b1;
				end
				if (bvalid && bready) begin
					bvalid <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
			rresp <= `RESP_OKAY;
			rdata <= '0;
			rd_pend <= 1'b0;
			rd_imem <= 1'b0;
			rd_err <= 1'b0;
		end else begin
			if (ar_hs) begin
				if (araddr == `REG_DISK_DATA || araddr == `REG_IMEM_DATA) begin
					rd_pend <= 1'b1;
					rd_imem <= (araddr == `REG_IMEM_DATA);
					rd_err <= (araddr == `REG_DISK_DATA) && busy;
				end else begin
					rvalid <= 1'b1;
					rdata <= rd_value;
					rresp <= rd_resp;
				end
			end else if (rd_pend) begin
				rd_pend <= 1'b0;	// memory output is valid now
				rvalid <= 1'b1;
				rdata <= rd_err ? '0 : (rd_imem ? imem_rdata : host_rdata);
				rresp <= rd_err ? `RESP_SLVERR : `RESP_OKAY;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/disk_loader_top.sv
`default_nettype none
`include "disk_consts.svh"

module disk_loader_top
	import disk_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  reg_addr_t  awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  disk_word_t wdata,
	input  logic       wvalid,
	output logic       wready,
	output logic [1:0] bresp,
	output logic       bvalid,
	input  logic       bready,
	input  reg_addr_t  araddr,
	input  logic       arvalid,
	output logic       arready,
	output disk_word_t rdata,
	output logic [1:0] rresp,
	output logic       rvalid,
	input  logic       rready
);

	logic       start;
	disk_addr_t src;
	imem_addr_t dst;
	xfer_len_t  len;
	logic       host_en;
	logic       host_we;
	disk_addr_t host_addr;
	disk_word_t host_wdata;
	disk_word_t host_rdata;
	logic       imem_rd;
	imem_addr_t imem_addr;
	disk_word_t imem_rdata;
	logic       xfer_done;
	logic       rd_en;
	disk_addr_t rd_addr;
	disk_word_t rd_data;
	logic       push;
	disk_word_t push_data;
	logic       pop;
	disk_word_t pop_data;
	logic       empty;
	logic [$clog2(`FIFO_DEPTH):0] fill;

	disk_loader_regs i_regs (.*);

	disk_store i_disk (.*);

	block_reader i_reader (.*);

	word_fifo i_fifo (.*);

	// host side of the instruction memory comes from the imem_* register port
	imem_bank i_imem (
		.host_rd    (imem_rd),
		.host_addr  (imem_addr),
		.host_rdata (imem_rdata),
		.*
	);

endmodule

`default_nettype wire

// File: hw/disk_store.sv
`default_nettype none
`include "disk_consts.svh"

module disk_store
	import disk_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       host_en,
	input  logic       host_we,
	input  disk_addr_t host_addr,
	input  disk_word_t host_wdata,
	output disk_word_t host_rdata,
	input  logic       rd_en,
	input  disk_addr_t rd_addr,
	output disk_word_t rd_data
);

	disk_word_t mem [`DISK_WORDS];

	logic host_in_range;
	logic rd_in_range;

	assign host_in_range = host_addr < `DISK_WORDS;
	assign rd_in_range = rd_addr < `DISK_WORDS;

	always_ff @(posedge clk) begin
		if (host_en && host_we && host_in_range) begin
			mem[host_addr] <= host_wdata;	// writes past the end are dropped
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			host_rdata <= '0;
			rd_data <= '0;
		end else begin
			if (host_en && !host_we) begin
				host_rdata <= host_in_range ? mem[host_addr] : '0;	// holds across writes
			end
			if (rd_en) begin
				rd_data <= rd_in_range ? mem[rd_addr] : '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/imem_bank.sv
`default_nettype none
`include "disk_consts.svh"

module imem_bank
	import disk_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  imem_addr_t dst,
	input  xfer_len_t  len,
	input  logic       empty,
	output logic       pop,
	input  disk_word_t pop_data,
	input  logic       host_rd,
	input  imem_addr_t host_addr,
	output disk_word_t host_rdata,
	output logic       xfer_done
);

	disk_word_t mem [`IMEM_WORDS];
	logic       active;
	imem_addr_t wr_addr;
	xfer_len_t  remaining;	// words still to write

	assign pop = active && !empty && !host_rd;	// host read owns the port this cycle

	// single port, pop and host_rd never overlap
	always_ff @(posedge clk) begin
		if (pop) begin
			mem[wr_addr] <= pop_data;
		end
		if (host_rd) begin
			host_rdata <= mem[host_addr];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			xfer_done <= 1'b0;
			wr_addr <= '0;
			remaining <= '0;
		end else begin
			xfer_done <= 1'b0;
			if (start && !active) begin
				active <= (len != '0);
				wr_addr <= dst;
				remaining <= len;
				xfer_done <= (len == '0);	// empty transfer finishes at once
			end else if (pop) begin
				wr_addr <= wr_addr + 1'b1;	// wraps mod 256
				remaining <= remaining - 1'b1;
				if (remaining == xfer_len_t'(1)) begin
					active <= 1'b0;
					xfer_done <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: loader/block_reader.sv
`default_nettype none
`include "disk_consts.svh"

module block_reader
	import disk_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          start,
	input  disk_addr_t                    src,
	input  xfer_len_t                     len,
	output logic                          rd_en,
	output disk_addr_t                    rd_addr,
	input  disk_word_t                    rd_data,
	output logic                          push,
	output disk_word_t                    push_data,
	input  logic [$clog2(`FIFO_DEPTH):0]  fill
);

	loader_state_t state;
	xfer_len_t     remaining;	// reads still to issue
	logic          credit_ok;

	// a word being pushed right now is not in fill yet
	assign credit_ok = (int'(fill) + int'(push)) < `FIFO_DEPTH;
	assign rd_en = (state == STREAM) && credit_ok;
	assign push_data = rd_data;	// disk data is valid the cycle after the read

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			remaining <= '0;
			rd_addr <= '0;
			push <= 1'b0;
		end else begin
			push <= rd_en;
			case (state)
				IDLE: begin
					if (start && len != '0) begin
						state <= STREAM;
						rd_addr <= src;
						remaining <= len;
					end
				end
				STREAM: begin
					if (rd_en) begin
						// parks on 511 so the rest of an overrunning block reads zero
						if (rd_addr != '1) begin
							rd_addr <= rd_addr + 1'b1;
						end
						remaining <= remaining - 1'b1;
						if (remaining == xfer_len_t'(1)) begin
							state <= DRAIN;	// last read issued
						end
					end
				end
				DRAIN: begin
					if (push) begin
						state <= IDLE;	// last word goes in now
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: loader/word_fifo.sv
`default_nettype none
`include "disk_consts.svh"

module word_fifo
	import disk_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          push,
	input  disk_word_t                    push_data,
	input  logic                          pop,
	output disk_word_t                    pop_data,
	output logic                          empty,
	output logic [$clog2(`FIFO_DEPTH):0]  fill
);

	localparam int PTR_W = $clog2(`FIFO_DEPTH);

	disk_word_t       fifo_mem [`FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;

	assign pop_data = fifo_mem[rd_ptr];	// head word falls through
	assign empty = (count == '0);
	assign fill = count;

	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;	// depth is a power of two
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module disk_loader_tb -f sources.f -o disk_loader_sim \
	&& ./obj_dir/disk_loader_sim 2>&1 | tee sim.log \
	|| { echo "build or simulation exited with an error"; exit 1; }

grep -qF "FAIL: see errors above" sim.log && exit 1 || exit 0

// File: sources.f
+incdir+common
common/disk_pkg.sv
hw/disk_store.sv
loader/block_reader.sv
loader/word_fifo.sv
hw/imem_bank.sv
hw/disk_loader_regs.sv
hw/disk_loader_top.sv
dv/disk_loader_sva.sv
dv/disk_loader_tb.sv
